/* src/aluPkg.sv */
// ALU package: value types, opcode and function codes, request and response structs
package aluPkg;

	// ==============================
	// Basic vector types
	// ==============================

	// Data word for operands, results, carry word and addresses
	typedef logic [63:0] value_t;
	// Primary opcode and function field under R1 and R2
	typedef logic [6:0] opcode_t;
	typedef logic [5:0] func_t;
	// Instruction length in bytes
	typedef logic [3:0] ilen_t;
	// Shift amount, bit 6 set means a shift of 64 or more
	typedef logic [6:0] shamt_t;

	// ==============================
	// Opcodes and function codes
	// ==============================

	// Register forms carry a function field
	localparam opcode_t R1    = 7'h01;
	localparam opcode_t R2    = 7'h02;
	localparam opcode_t ADDI  = 7'h04;
	localparam opcode_t SUBFI = 7'h05;
	localparam opcode_t ANDI  = 7'h08;
	localparam opcode_t ORI   = 7'h09;
	localparam opcode_t XORI  = 7'h0A;
	localparam opcode_t SLTI  = 7'h10;
	localparam opcode_t SLTUI = 7'h11;
	localparam opcode_t SEQI  = 7'h12;
	localparam opcode_t CMPI  = 7'h13;
	localparam opcode_t SLLI  = 7'h18;
	localparam opcode_t SRLI  = 7'h19;
	localparam opcode_t SRAI  = 7'h1A;
	localparam opcode_t JMP   = 7'h20;

	// R1 functions, single source operand
	localparam func_t CNTLZ = 6'h00;
	localparam func_t CNTLO = 6'h01;

	// R2 functions, up to three source operands
	localparam func_t ADD  = 6'h04;
	localparam func_t SUB  = 6'h05;
	localparam func_t AND  = 6'h08;
	localparam func_t OR   = 6'h09;
	localparam func_t XOR  = 6'h0A;
	localparam func_t SLT  = 6'h10;
	localparam func_t SLTU = 6'h11;
	localparam func_t SEQ  = 6'h12;
	localparam func_t CMP  = 6'h13;
	localparam func_t SLL  = 6'h18;
	localparam func_t SRL  = 6'h19;
	localparam func_t SRA  = 6'h1A;
	localparam func_t ROL  = 6'h1B;
	localparam func_t ROR  = 6'h1C;
	localparam func_t MUX  = 6'h20;

	// ==============================
	// Structs
	// ==============================

	// Compare flags, eq in the top bit down to geu in bit 0
	typedef struct packed {
		logic eq;
		logic ne;
		logic lt;
		logic le;
		logic gt;
		logic ge;
		logic ltu;
		logic leu;
		logic gtu;
		logic geu;
	} cmpFlags_t;

	// Bit positions of the flags inside a CMP result
	localparam int unsigned CMP_EQ  = 9;
	localparam int unsigned CMP_NE  = 8;
	localparam int unsigned CMP_LT  = 7;
	localparam int unsigned CMP_LE  = 6;
	localparam int unsigned CMP_GT  = 5;
	localparam int unsigned CMP_GE  = 4;
	localparam int unsigned CMP_LTU = 3;
	localparam int unsigned CMP_LEU = 2;
	localparam int unsigned CMP_GTU = 1;
	localparam int unsigned CMP_GEU = 0;

	// One issued instruction with its operands
	typedef struct packed {
		opcode_t opcode;
		func_t   func;
		value_t  xa;
		value_t  xb;
		value_t  xc;
		value_t  imm;
		value_t  ip;
		ilen_t   ilen;
	} aluReq_t;

	// Result, carry word and link address of one instruction
	typedef struct packed {
		value_t res;
		value_t carryRes;
		value_t linkAddr;
	} aluResp_t;

endpackage

/* src/aluCompare.sv */
// Compare unit giving packed signed and unsigned order flags of two values
`timescale 1ns/1ps

module aluCompare
(
	input  aluPkg::value_t    a,
	input  aluPkg::value_t    b,
	output aluPkg::cmpFlags_t flags
);

	logic isEq;
	logic isLt;
	logic isLtu;

	// Three base relations, every other flag derives from these
	assign isEq  = (a == b);
	assign isLt  = ($signed(a) < $signed(b));
	assign isLtu = (a < b);

	// Equality pair
	assign flags.eq = isEq;
	assign flags.ne = ~isEq;

	// Signed ordering, two's complement view of both operands
	assign flags.lt = isLt;
	assign flags.le = isLt | isEq;
	assign flags.gt = ~(isLt | isEq);
	assign flags.ge = ~isLt;

	// Unsigned ordering
	assign flags.ltu = isLtu;
	assign flags.leu = isLtu | isEq;
	assign flags.gtu = ~(isLtu | isEq);
	assign flags.geu = ~isLtu;

endmodule

/* src/aluCountLeading.sv */
// Leading zero counter, with input inversion to count leading ones
`timescale 1ns/1ps

module aluCountLeading
(
	input  aluPkg::value_t value,
	input  logic           invert,
	output logic [6:0]     count
);

	localparam int W = $bits(aluPkg::value_t);

	aluPkg::value_t src;

	// Leading ones of the value are leading zeros of its complement
	assign src = invert ? ~value : value;

	// Priority search from the low end upward
	// The highest set bit is visited last and so sets the final count
	always_comb
	begin
		count = 7'(W);
		for (int i = 0; i < W; i++)
		begin
			if (src[i])
			begin
				count = 7'(W - 1 - i);
			end
		end
	end

	// The count stops at 64 for an all-zero source
	// No bit above the counted zeros may be set
	assert property (@(count) (count <= 7'(W)) && ((src >> (W - int'(count))) == '0))
	else
		$error("Leading count %0d exceeds the word width or skips a set bit", count);

endmodule

/* src/aluShifter.sv */
// Double-width shifter giving shift and rotate results and the shifted-out bits
`timescale 1ns/1ps

module aluShifter
(
	input  aluPkg::value_t value,
	input  aluPkg::shamt_t amount,
	input  logic           arith,
	output aluPkg::value_t shlOut,
	output aluPkg::value_t shrOut,
	output aluPkg::value_t rolOut,
	output aluPkg::value_t rorOut,
	output aluPkg::value_t shlOver,
	output aluPkg::value_t shrUnder
);

	localparam int W = $bits(aluPkg::value_t);

	// ==============================
	// Shifts
	// ==============================

	logic           fill;
	logic [2*W-1:0] shlWide;
	logic [4*W-1:0] shrWide;

	// Sign fill only for arithmetic right shifts
	assign fill = arith & value[W-1];

	// Left shift with the value in the low half
	// The upper half collects the bits pushed out
	assign shlWide = {{W{1'b0}}, value} << amount;

	// Right shift with the value in the second word from the bottom
	// Two fill words on top supply sign bits for every amount from 64 to 127
	assign shrWide = {{2*W{fill}}, value, {W{1'b0}}} >> amount;

	assign shlOut  = shlWide[W-1:0];
	assign shlOver = shlWide[2*W-1:W];

	// Result sits in the second word, the bits shifted out land below it
	assign shrOut   = shrWide[2*W-1:W];
	assign shrUnder = shrWide[W-1:0];

	// ==============================
	// Rotates
	// ==============================

	logic [5:0]     rotAmt;
	logic [2*W-1:0] rolWide;
	logic [2*W-1:0] rorWide;

	// Rotates use the amount modulo 64
	assign rotAmt = amount[5:0];

	assign rolWide = {{W{1'b0}}, value} << rotAmt;
	assign rorWide = {value, {W{1'b0}}} >> rotAmt;

	// Or the bits that left one half back into the other
	assign rolOut = rolWide[W-1:0] | rolWide[2*W-1:W];
	assign rorOut = rorWide[2*W-1:W] | rorWide[W-1:0];

endmodule

/* src/aluCore.sv */
// Combinational ALU decode producing result, carry word and link address
`timescale 1ns/1ps

module aluCore
(
	input  aluPkg::aluReq_t  req,
	output aluPkg::aluResp_t resp
);

	localparam int W = $bits(aluPkg::value_t);

	// ==============================
	// Functional units
	// ==============================

	aluPkg::cmpFlags_t cmpReg;
	aluPkg::cmpFlags_t cmpImm;

	// Register against register compare
	aluCompare u_cmpReg
	(
		.a    (req.xa),
		.b    (req.xb),
		.flags(cmpReg)
	);

	// Register against immediate compare
	aluCompare u_cmpImm
	(
		.a    (req.xa),
		.b    (req.imm),
		.flags(cmpImm)
	);

	logic       cntInvert;
	logic [6:0] cntOut;

	// CNTLO reuses the zero counter on the complemented operand
	assign cntInvert = (req.func == aluPkg::CNTLO);

	aluCountLeading u_cntLead
	(
		.value (req.xa),
		.invert(cntInvert),
		.count (cntOut)
	);

	aluPkg::shamt_t shAmt;
	logic           shArith;
	aluPkg::value_t shlOut;
	aluPkg::value_t shrOut;
	aluPkg::value_t rolOut;
	aluPkg::value_t rorOut;
	aluPkg::value_t shlOver;
	aluPkg::value_t shrUnder;

	// Register forms take the amount from xb, immediate forms from imm
	assign shAmt   = (req.opcode == aluPkg::R2) ? req.xb[6:0] : req.imm[6:0];
	assign shArith = (req.opcode == aluPkg::SRAI) ||
		((req.opcode == aluPkg::R2) && (req.func == aluPkg::SRA));

	aluShifter u_shift
	(
		.value   (req.xa),
		.amount  (shAmt),
		.arith   (shArith),
		.shlOut  (shlOut),
		.shrOut  (shrOut),
		.rolOut  (rolOut),
		.rorOut  (rorOut),
		.shlOver (shlOver),
		.shrUnder(shrUnder)
	);

	// ==============================
	// Adders and misc terms
	// ==============================

	// One extra bit so the carry out falls into bit 64
	logic [W:0]     addSum;
	logic [W:0]     subDiff;
	aluPkg::value_t muxOut;
	aluPkg::value_t retAddr;

	assign addSum  = {1'b0, req.xa} + {1'b0, req.xb} + {1'b0, req.xc};
	assign subDiff = {1'b0, req.xa} - {1'b0, req.xb};

	// Each bit from xb where xa is set, else from xc
	assign muxOut  = (req.xa & req.xb) | (~req.xa & req.xc);
	assign retAddr = req.ip + aluPkg::value_t'(req.ilen);

	// ==============================
	// Decode
	// ==============================

	always_comb
	begin
		// Most operations pass xc through as the link and produce no carry
		resp.res      = '0;
		resp.carryRes = '0;
		resp.linkAddr = req.xc;
		case (req.opcode)
		aluPkg::R1:
			case (req.func)
			aluPkg::CNTLZ, aluPkg::CNTLO: resp.res = aluPkg::value_t'(cntOut);
			default: resp.linkAddr = '0;
			endcase
		aluPkg::R2:
			case (req.func)
			aluPkg::ADD:
			begin
				resp.res      = addSum[W-1:0];
				resp.carryRes = aluPkg::value_t'(addSum[W]);
			end
			aluPkg::SUB:
			begin
				resp.res      = subDiff[W-1:0];
				resp.carryRes = aluPkg::value_t'(subDiff[W]);
			end
			aluPkg::AND:  resp.res = req.xa & req.xb & req.xc;
			aluPkg::OR:   resp.res = req.xa | req.xb | req.xc;
			aluPkg::XOR:  resp.res = req.xa ^ req.xb ^ req.xc;
			// Register set-on-compare returns xc rather than a plain 1
			aluPkg::SLT:  resp.res = cmpReg.lt ? req.xc : '0;
			aluPkg::SLTU: resp.res = cmpReg.ltu ? req.xc : '0;
			aluPkg::SEQ:  resp.res = cmpReg.eq ? req.xc : '0;
			aluPkg::CMP:  resp.res = aluPkg::value_t'(cmpReg);
			aluPkg::SLL:
			begin
				resp.res      = shlOut;
				resp.carryRes = shlOver;
			end
			aluPkg::SRL, aluPkg::SRA:
			begin
				resp.res      = shrOut;
				resp.carryRes = shrUnder;
			end
			aluPkg::ROL:  resp.res = rolOut;
			aluPkg::ROR:  resp.res = rorOut;
			aluPkg::MUX:  resp.res = muxOut;
			default: resp.linkAddr = '0;
			endcase
		aluPkg::ADDI:  resp.res = req.xa + req.imm;
		aluPkg::SUBFI: resp.res = req.imm - req.xa;
		aluPkg::ANDI:  resp.res = req.xa & req.imm;
		aluPkg::ORI:   resp.res = req.xa | req.imm;
		aluPkg::XORI:  resp.res = req.xa ^ req.imm;
		aluPkg::SLTI:  resp.res = aluPkg::value_t'(cmpImm.lt);
		aluPkg::SLTUI: resp.res = aluPkg::value_t'(cmpImm.ltu);
		aluPkg::SEQI:  resp.res = aluPkg::value_t'(cmpImm.eq);
		aluPkg::CMPI:  resp.res = aluPkg::value_t'(cmpImm);
		aluPkg::SLLI:
		begin
			resp.res      = shlOut;
			resp.carryRes = shlOver;
		end
		aluPkg::SRLI, aluPkg::SRAI:
		begin
			resp.res      = shrOut;
			resp.carryRes = shrUnder;
		end
		// Jump writes the return address to both result and link
		aluPkg::JMP:
		begin
			resp.res      = retAddr;
			resp.linkAddr = retAddr;
		end
		default: resp.linkAddr = '0;
		endcase
	end

endmodule

/* src/aluExecUnit.sv */
// Integer execution unit with a single registered ALU stage
`timescale 1ns/1ps

module aluExecUnit
(
	input  logic             clk,
	input  logic             rst,
	input  logic             issueValid,
	input  aluPkg::aluReq_t  req,
	output logic             resultValid,
	output aluPkg::aluResp_t resp
);

	// ==============================
	// Combinational core
	// ==============================

	aluPkg::aluResp_t coreResp;

	aluCore u_core
	(
		.req (req),
		.resp(coreResp)
	);

	// ==============================
	// Result register
	// ==============================

	// One cycle of latency, a new request is taken every cycle
	// Response holds its last value while no instruction is issued
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resultValid <= 1'b0;
			resp        <= '0;
		end
		else
		begin
			resultValid <= issueValid;
			if (issueValid)
			begin
				resp <= coreResp;
			end
		end
	end

	// The strobe must resolve to 0 or 1 every cycle once out of reset
	assert property (@(posedge clk) disable iff (rst) !$isunknown(resultValid))
	else
		$error("resultValid is unknown after reset release");

endmodule

/* test/aluExecUnitTb.sv */
// Testbench for the ALU execution unit, table driven against a reference model
`timescale 1ns/1ps

module aluExecUnitTb;

	// One table row, a request and a flag that asks for fresh random operands
	typedef struct packed {
		aluPkg::aluReq_t req;
		logic            rnd;
	} stimEntry_t;

	localparam int waitLimit   = 16;
	localparam int burstLength = 40;

	logic             clk;
	logic             rst;
	logic             issueValid;
	aluPkg::aluReq_t  req;
	logic             resultValid;
	aluPkg::aluResp_t resp;

	int               errors;
	int               checks;
	logic [31:0]      seed;
	stimEntry_t       stimTable[$];
	aluPkg::aluResp_t prevExp;
	logic             haveExp;
	int               pick;

	aluExecUnit u_dut
	(
		.clk        (clk),
		.rst        (rst),
		.issueValid (issueValid),
		.req        (req),
		.resultValid(resultValid),
		.resp       (resp)
	);

	// 8 ns clock period
	always #4 clk = ~clk;

	// ==============================
	// Random numbers
	// ==============================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRand();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic aluPkg::value_t randWord();
		logic [31:0] hi;
		hi = nextRand();
		return {hi, nextRand()};
	endfunction

	// ==============================
	// Reference model
	// ==============================

	// Flags in cmpFlags_t order, eq first and geu last
	function automatic logic [9:0] compareFlags(aluPkg::value_t a, aluPkg::value_t b);
		return {a == b, a != b, $signed(a) < $signed(b), $signed(a) <= $signed(b),
			$signed(a) > $signed(b), $signed(a) >= $signed(b), a < b, a <= b, a > b, a >= b};
	endfunction

	// Scan down from the top bit and stop counting at the first one
	function automatic int leadZeros(aluPkg::value_t v);
		int n;
		n = 64;
		for (int i = 63; i >= 0; i--)
		begin
			if (v[i] && n == 64)
				n = 63 - i;
		end
		return n;
	endfunction

	function automatic aluPkg::aluResp_t expectResp(aluPkg::aluReq_t r);
		aluPkg::aluResp_t e;
		aluPkg::value_t   other;
		aluPkg::value_t   fillWord;
		logic [65:0]      sum3;
		logic [64:0]      diff;
		int unsigned      amt;
		int unsigned      rot;
		int               mode;
		logic             known;
		e = '0;
		e.linkAddr = r.xc;
		known = 1'b1;
		mode = 0;
		// Shift amount is xb for register forms and imm otherwise
		other = (r.opcode == aluPkg::R2) ? r.xb : r.imm;
		amt = 32'(other[6:0]);
		rot = amt % 64;
		sum3 = {2'b0, r.xa} + {2'b0, r.xb} + {2'b0, r.xc};
		diff = {1'b0, r.xa} - {1'b0, r.xb};
		case (r.opcode)
		aluPkg::R1:
			case (r.func)
			aluPkg::CNTLZ: e.res = aluPkg::value_t'(leadZeros(r.xa));
			aluPkg::CNTLO: e.res = aluPkg::value_t'(leadZeros(~r.xa));
			default: known = 1'b0;
			endcase
		aluPkg::R2:
			case (r.func)
			aluPkg::ADD:
			begin
				e.res = sum3[63:0];
				e.carryRes = {63'b0, sum3[64]};
			end
			aluPkg::SUB:
			begin
				e.res = diff[63:0];
				e.carryRes = {63'b0, diff[64]};
			end
			aluPkg::AND:  e.res = r.xa & r.xb & r.xc;
			aluPkg::OR:   e.res = r.xa | r.xb | r.xc;
			aluPkg::XOR:  e.res = r.xa ^ r.xb ^ r.xc;
			aluPkg::SLT:  e.res = ($signed(r.xa) < $signed(r.xb)) ? r.xc : '0;
			aluPkg::SLTU: e.res = (r.xa < r.xb) ? r.xc : '0;
			aluPkg::SEQ:  e.res = (r.xa == r.xb) ? r.xc : '0;
			aluPkg::CMP:  e.res = {54'b0, compareFlags(r.xa, r.xb)};
			aluPkg::SLL:  mode = 1;
			aluPkg::SRL:  mode = 2;
			aluPkg::SRA:  mode = 3;
			aluPkg::ROL:  e.res = (r.xa << rot) | (r.xa >> (64 - rot));
			aluPkg::ROR:  e.res = (r.xa >> rot) | (r.xa << (64 - rot));
			aluPkg::MUX:  e.res = (r.xb & r.xa) | (r.xc & ~r.xa);
			default: known = 1'b0;
			endcase
		aluPkg::ADDI:  e.res = r.xa + r.imm;
		aluPkg::SUBFI: e.res = r.imm - r.xa;
		aluPkg::ANDI:  e.res = r.xa & r.imm;
		aluPkg::ORI:   e.res = r.xa | r.imm;
		aluPkg::XORI:  e.res = r.xa ^ r.imm;
		aluPkg::SLTI:  e.res = {63'b0, $signed(r.xa) < $signed(r.imm)};
		aluPkg::SLTUI: e.res = {63'b0, r.xa < r.imm};
		aluPkg::SEQI:  e.res = {63'b0, r.xa == r.imm};
		aluPkg::CMPI:  e.res = {54'b0, compareFlags(r.xa, r.imm)};
		aluPkg::SLLI:  mode = 1;
		aluPkg::SRLI:  mode = 2;
		aluPkg::SRAI:  mode = 3;
		aluPkg::JMP:
		begin
			e.res = r.ip + 64'(r.ilen);
			e.linkAddr = e.res;
		end
		default: known = 1'b0;
		endcase
		// Shifts by 64 bits in SystemVerilog give zero, which covers the amount 0 edge
		fillWord = (mode == 3 && r.xa[63]) ? '1 : '0;
		if (mode == 1 && amt < 64)
		begin
			e.res = r.xa << amt;
			e.carryRes = r.xa >> (64 - amt);
		end
		else if (mode == 1)
		begin
			e.res = '0;
			e.carryRes = r.xa << (amt - 64);
		end
		else if (mode >= 2 && amt < 64)
		begin
			e.res = (r.xa >> amt) | (fillWord << (64 - amt));
			e.carryRes = r.xa << (64 - amt);
		end
		else if (mode >= 2)
		begin
			e.res = fillWord;
			e.carryRes = (r.xa >> (amt - 64)) | (fillWord << (128 - amt));
		end
		if (!known)
			e = '0;
		return e;
	endfunction

	// ==============================
	// Stimulus table
	// ==============================

	task automatic addEntry(aluPkg::opcode_t op, aluPkg::func_t fn, aluPkg::value_t xa,
		aluPkg::value_t xb, aluPkg::value_t xc, aluPkg::value_t imm, logic rnd);
		stimEntry_t ent;
		ent.req = '{opcode: op, func: fn, xa: xa, xb: xb, xc: xc, imm: imm,
			ip: 64'h0000_7FFF_FFFF_FFFC, ilen: 4'd6};
		ent.rnd = rnd;
		stimTable.push_back(ent);
	endtask

	task automatic buildTable();
		aluPkg::func_t   shFuncs[5];
		aluPkg::opcode_t shOps[3];
		int              amts[5];
		aluPkg::value_t  ones;
		aluPkg::value_t  msb;
		shFuncs = '{aluPkg::SLL, aluPkg::SRL, aluPkg::SRA, aluPkg::ROL, aluPkg::ROR};
		shOps = '{aluPkg::SLLI, aluPkg::SRLI, aluPkg::SRAI};
		amts = '{0, 1, 63, 64, 100};
		ones = '1;
		msb = 64'h8000_0000_0000_0000;
		// Adder carry and borrow at the word edge
		addEntry(aluPkg::R2, aluPkg::ADD, ones, ones, ones, 0, 0);
		addEntry(aluPkg::R2, aluPkg::ADD, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R2, aluPkg::SUB, 64'h1, ones, 64'h33, 0, 0);
		addEntry(aluPkg::R2, aluPkg::SUB, ones, ones, 64'h44, 0, 0);
		addEntry(aluPkg::ADDI, 0, ones, 0, 64'h5, 64'h1, 0);
		addEntry(aluPkg::SUBFI, 0, 64'h7, 0, 64'h6, 64'h5, 0);
		addEntry(aluPkg::R2, aluPkg::AND, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R2, aluPkg::OR, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R2, aluPkg::XOR, 0, 0, 0, 0, 1);
		addEntry(aluPkg::ANDI, 0, 0, 0, 0, 0, 1);
		addEntry(aluPkg::ORI, 0, 0, 0, 0, 0, 1);
		addEntry(aluPkg::XORI, 0, 0, 0, 0, 0, 1);
		// Most negative against one splits the signed and unsigned answers
		addEntry(aluPkg::R2, aluPkg::SLT, msb, 64'h1, 64'h55, 0, 0);
		addEntry(aluPkg::R2, aluPkg::SLT, 64'h1, msb, 64'h55, 0, 0);
		addEntry(aluPkg::R2, aluPkg::SLTU, msb, 64'h1, 64'h66, 0, 0);
		addEntry(aluPkg::R2, aluPkg::SLTU, 64'h1, msb, 64'h66, 0, 0);
		addEntry(aluPkg::R2, aluPkg::SEQ, 64'h5, 64'h5, 64'hAA, 0, 0);
		addEntry(aluPkg::R2, aluPkg::SEQ, 64'h5, 64'h6, 64'hAA, 0, 0);
		addEntry(aluPkg::SLTI, 0, msb, 0, 64'h1, 64'h1, 0);
		addEntry(aluPkg::SLTUI, 0, msb, 0, 64'h2, 64'h1, 0);
		addEntry(aluPkg::SEQI, 0, 64'h7, 0, 64'h3, 64'h7, 0);
		addEntry(aluPkg::SEQI, 0, 64'h7, 0, 64'h3, 64'h8, 0);
		addEntry(aluPkg::R2, aluPkg::CMP, msb, 64'h1, 64'h9, 0, 0);
		addEntry(aluPkg::R2, aluPkg::CMP, ones, ones, 64'h9, 0, 0);
		addEntry(aluPkg::CMPI, 0, 64'h1, 0, 64'h8, msb, 0);
		// Every shift and rotate at the amounts 0, 1, 63, 64 and 100 on a negative source
		foreach (amts[i])
		begin
			foreach (shFuncs[j])
				addEntry(aluPkg::R2, shFuncs[j], 64'h8123_4567_89AB_CDEF,
					aluPkg::value_t'(amts[i]), 64'h0C0C_0C0C_0C0C_0C0C, 0, 0);
			foreach (shOps[j])
				addEntry(shOps[j], 0, 64'h8123_4567_89AB_CDEF, 0, 64'h0D0D,
					aluPkg::value_t'(amts[i]), 0);
		end
		addEntry(aluPkg::R1, aluPkg::CNTLZ, 0, 0, 64'h11, 0, 0);
		addEntry(aluPkg::R1, aluPkg::CNTLZ, ones, 0, 64'h12, 0, 0);
		addEntry(aluPkg::R1, aluPkg::CNTLZ, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R1, aluPkg::CNTLO, 0, 0, 64'h13, 0, 0);
		addEntry(aluPkg::R1, aluPkg::CNTLO, ones, 0, 64'h14, 0, 0);
		addEntry(aluPkg::R1, aluPkg::CNTLO, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R2, aluPkg::MUX, 0, 0, 0, 0, 1);
		addEntry(aluPkg::JMP, 0, 0, 0, 64'h77, 0, 0);
		addEntry(aluPkg::JMP, 0, 0, 0, 0, 0, 1);
		// Unknown codes must clear every output
		addEntry(7'h7F, 0, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R2, 6'h3F, 0, 0, 0, 0, 1);
		addEntry(aluPkg::R1, 6'h3E, 0, 0, 0, 0, 1);
	endtask

	function automatic aluPkg::aluReq_t prepareReq(stimEntry_t ent);
		aluPkg::aluReq_t r;
		logic [31:0]     t;
		r = ent.req;
		if (ent.rnd)
		begin
			r.xa = randWord();
			r.xb = randWord();
			r.xc = randWord();
			r.imm = randWord();
			r.ip = randWord();
			t = nextRand();
			r.ilen = t[3:0];
		end
		return r;
	endfunction

	// ==============================
	// Checks and issue
	// ==============================

	task automatic checkValue(string name, aluPkg::value_t got, aluPkg::value_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkResp(aluPkg::aluResp_t exp);
		checkValue("resp.res", resp.res, exp.res);
		checkValue("resp.carryRes", resp.carryRes, exp.carryRes);
		checkValue("resp.linkAddr", resp.linkAddr, exp.linkAddr);
	endtask

	// Called a little after a rising edge; returns at the same phase once the result is in
	task automatic runEntry(aluPkg::aluReq_t r);
		int waited;
		req = r;
		issueValid = 1'b1;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			issueValid = 1'b0;
			waited++;
		end
		while (!resultValid && waited < waitLimit);
		assert (resultValid)
		else
		begin
			errors++;
			$display("Timeout at %0t: resultValid never rose after issue", $time);
		end
		if (resultValid)
		begin
			checkValue("latency", aluPkg::value_t'(waited), 64'd1);
			checkResp(expectResp(r));
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		// A jump issued while reset is held must not reach the result register
		issueValid = 1'b1;
		req = '0;
		req.opcode = aluPkg::JMP;
		req.ip = 64'h0000_0000_0000_1000;
		req.xc = 64'h0000_0000_0000_0BAD;
		errors = 0;
		checks = 0;
		seed = 32'h6947;
		haveExp = 1'b0;
		buildTable();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		issueValid = 1'b0;
		// Idle after reset keeps the strobe low and the response cleared
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
			#1;
			checkValue("resultValid", aluPkg::value_t'(resultValid), 64'd0);
			checkResp('0);
		end
		foreach (stimTable[i])
			runEntry(prepareReq(stimTable[i]));
		// Back-to-back issue, each result is checked one edge after its issue
		for (int k = 0; k <= burstLength; k++)
		begin
			@(posedge clk);
			#1;
			if (haveExp)
			begin
				checkValue("resultValid", aluPkg::value_t'(resultValid), 64'd1);
				checkResp(prevExp);
			end
			issueValid = (k < burstLength);
			if (k < burstLength)
			begin
				pick = int'(nextRand() % 32'(stimTable.size()));
				req = prepareReq(stimTable[pick]);
				prevExp = expectResp(req);
				haveExp = 1'b1;
			end
		end
		// A gap in issue drops the strobe while the response holds
		@(posedge clk);
		#1;
		checkValue("resultValid", aluPkg::value_t'(resultValid), 64'd0);
		checkResp(prevExp);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* aluExecUnit.f */
src/aluPkg.sv
src/aluCompare.sv
src/aluCountLeading.sv
src/aluShifter.sv
src/aluCore.sv
src/aluExecUnit.sv
test/aluExecUnitTb.sv

/* runSim.sh */
#!/bin/sh
# Build the ALU testbench with Verilator, run it and search the output for the pass line.
# The exit status is nonzero when the build fails or the pass line is missing.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module aluExecUnitTb \
	-f aluExecUnit.f -o aluSim &&
	./obj_dir/aluSim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null ||
	{ echo "ALU simulation run did not pass"; exit 1; }
